// File: list.f
logic/exec_pkg.sv
logic/op_decode.sv
logic/int_alu.sv
logic/branch_unit.sv
logic/mem_addr_gen.sv
logic/count_lead_unit.sv
logic/execute_stage.sv
tests/tb_clock.sv
tests/tb_execute.sv

// File: tests/tb_execute.sv
`timescale 1ns/100ps

module tb_execute;
    import exec_pkg::*;

    // alu 96 ops, branches 48, memory 24, misaligned and exceptions 10, hi/lo 20, counts 12
    localparam int MAX_CYCLES = 4 + 96 * 3 + 48 * 3 + 24 * 8 + 10 * 3 + 20 * 12 + 12 * 38 + 200;

    logic clk, resetn;
    logic valid_i, ready_i, int_i, data_addr_ok_i;
    issue_t issue_i;
    logic done_o, valid_o, branch_o, commit_o;
    stage_out_t out_o;
    mem_req_t mem_o;
    logic [XLEN-1:0] target_pc_o;
    commit_t commit_info_o;

    logic [XLEN-1:0] exp_result, exp_target, exp_eaddr, hi_model, lo_model;
    logic [REG_AW-1:0] exp_waddr;
    logic exp_wb, exp_branch;
    exc_code_e exp_code;
    mem_req_t exp_mem;
    logic chk_out, chk_br, chk_mem, chk_exc, chk_noexc, chk_noval;
    int errors, tests, cycles;

    exec_op_e alu_ops[$] = '{OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_AND, OP_OR, OP_XOR, OP_NOR,
        OP_SLT, OP_SLTU, OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV, OP_ADDI,
        OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
    exec_op_e br_ops[$] = '{OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_BLTZ, OP_BGEZ,
        OP_BLTZAL, OP_BGEZAL, OP_J, OP_JAL, OP_JR, OP_JALR};

    tb_clock i_clock (.clk_o(clk), .resetn_o(resetn));

    execute_stage i_dut (
        .clk(clk), .resetn(resetn), .valid_i(valid_i), .issue_i(issue_i),
        .ready_i(ready_i), .int_i(int_i), .data_addr_ok_i(data_addr_ok_i),
        .done_o(done_o), .valid_o(valid_o), .out_o(out_o), .mem_o(mem_o),
        .branch_o(branch_o), .target_pc_o(target_pc_o), .commit_o(commit_o),
        .commit_info_o(commit_info_o)
    );

    task automatic report_err(input string msg);
        errors++;
        $display("error %0t: %s", $time, msg);
    endtask

    function automatic logic [5:0] lead_count(input logic [31:0] v, input logic ones);
        int n;
        n = 0;
        while (n < 32 && v[31-n] == ones) n++;
        return n[5:0];
    endfunction

    function automatic logic writes(input exec_op_e op);
        return !(op inside {OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_BLTZ, OP_BGEZ, OP_J, OP_JR,
            OP_MTHI, OP_MTLO, OP_SB, OP_SH, OP_SW, OP_NOP, OP_RESERVED});
    endfunction

    function automatic logic [31:0] eff_addr(input issue_t s);
        return s.rs_val + {{16{s.imm[15]}}, s.imm};
    endfunction

    function automatic logic [4:0] dest_reg(input issue_t s);
        if (s.op inside {OP_BLTZAL, OP_BGEZAL, OP_JAL}) return 5'd31;
        if (s.op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI,
            OP_LUI, OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW}) return s.rt;
        return writes(s.op) ? s.rd : 5'd0;
    endfunction

    function automatic logic [31:0] op_result(input issue_t s);
        logic [31:0] se, ze;
        se = {{16{s.imm[15]}}, s.imm};
        ze = {16'h0000, s.imm};
        case (s.op)
            OP_ADD, OP_ADDU: return s.rs_val + s.rt_val;
            OP_SUB, OP_SUBU: return s.rs_val - s.rt_val;
            OP_AND:   return s.rs_val & s.rt_val;
            OP_OR:    return s.rs_val | s.rt_val;
            OP_XOR:   return s.rs_val ^ s.rt_val;
            OP_NOR:   return ~(s.rs_val | s.rt_val);
            OP_SLT:   return {31'd0, $signed(s.rs_val) < $signed(s.rt_val)};
            OP_SLTU:  return {31'd0, s.rs_val < s.rt_val};
            OP_SLL:   return s.rt_val << s.sa;
            OP_SRL:   return s.rt_val >> s.sa;
            OP_SRA:   return $signed(s.rt_val) >>> s.sa;
            OP_SLLV:  return s.rt_val << s.rs_val[4:0];
            OP_SRLV:  return s.rt_val >> s.rs_val[4:0];
            OP_SRAV:  return $signed(s.rt_val) >>> s.rs_val[4:0];
            OP_ADDI, OP_ADDIU: return s.rs_val + se;
            OP_SLTI:  return {31'd0, $signed(s.rs_val) < $signed(se)};
            OP_SLTIU: return {31'd0, s.rs_val < se};
            OP_ANDI:  return s.rs_val & ze;
            OP_ORI:   return s.rs_val | ze;
            OP_XORI:  return s.rs_val ^ ze;
            OP_LUI:   return {s.imm, 16'h0000};
            OP_BLTZAL, OP_BGEZAL, OP_JAL, OP_JALR: return s.pc + 32'd8;
            OP_MFHI:  return hi_model;
            OP_MFLO:  return lo_model;
            OP_CLZ:   return {26'd0, lead_count(s.rs_val, 1'b0)};
            OP_CLO:   return {26'd0, lead_count(s.rs_val, 1'b1)};
            default:  return 32'd0;
        endcase
    endfunction

    function automatic logic branch_taken(input issue_t s);
        case (s.op)
            OP_BEQ:  return s.rs_val == s.rt_val;
            OP_BNE:  return s.rs_val != s.rt_val;
            OP_BLEZ: return $signed(s.rs_val) <= 0;
            OP_BGTZ: return $signed(s.rs_val) > 0;
            OP_BLTZ, OP_BLTZAL: return $signed(s.rs_val) < 0;
            OP_BGEZ, OP_BGEZAL: return $signed(s.rs_val) >= 0;
            OP_J, OP_JAL, OP_JR, OP_JALR: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic mem_req_t mem_request(input issue_t s);
        mem_req_t m;
        logic [31:0] ea;
        m = '0;
        ea = eff_addr(s);
        m.wr = s.op inside {OP_SB, OP_SH, OP_SW};
        m.size = (s.op inside {OP_LB, OP_LBU, OP_SB}) ? SIZE_BYTE
               : (s.op inside {OP_LH, OP_LHU, OP_SH}) ? SIZE_HALF : SIZE_WORD;
        m.cached = ea[31:29] == 3'b100;
        m.addr = (ea[31:30] == 2'b10) ? {3'b000, ea[28:2], 2'b00} : {ea[31:2], 2'b00};
        case (m.size)
            SIZE_BYTE: m.wdata = {4{s.rt_val[7:0]}};
            SIZE_HALF: m.wdata = {2{s.rt_val[15:0]}};
            default:   m.wdata = s.rt_val;
        endcase
        if (m.wr) begin
            m.wstrb = (m.size == SIZE_WORD) ? 4'b1111
                    : ((m.size == SIZE_HALF ? 4'b0011 : 4'b0001) << ea[1:0]);
        end
        return m;
    endfunction

    a_out: assert property (@(posedge clk) chk_out |-> valid_o && out_o.waddr == exp_waddr
        && (!exp_wb || out_o.result == exp_result) && out_o.pc == issue_i.pc
        && out_o.op == issue_i.op && out_o.rt_val == issue_i.rt_val
        && out_o.eaddr == exp_eaddr)
        else report_err("registered result, write address or instruction fields mismatch");
    a_branch: assert property (@(posedge clk) chk_br |-> branch_o == exp_branch
        && (!exp_branch || target_pc_o == exp_target))
        else report_err("branch decision or target mismatch");
    a_mem: assert property (@(posedge clk) chk_mem |-> mem_o.req && mem_o.wr == exp_mem.wr
        && mem_o.wstrb == exp_mem.wstrb && mem_o.size == exp_mem.size
        && mem_o.cached == exp_mem.cached && mem_o.addr == exp_mem.addr
        && (!exp_mem.wr || mem_o.wdata == exp_mem.wdata))
        else report_err("memory request fields mismatch");
    a_mem_wait: assert property (@(posedge clk) chk_mem && !data_addr_ok_i |-> !done_o)
        else report_err("done_o high before the address was accepted");
    a_exc: assert property (@(posedge clk) chk_exc |-> commit_o && !mem_o.req
        && commit_info_o.code == exp_code && commit_info_o.epc == issue_i.pc
        && commit_info_o.bvaddr == exp_eaddr)
        else report_err("exception commit mismatch");
    a_noexc: assert property (@(posedge clk) chk_noexc |-> !commit_o)
        else report_err("unexpected exception commit");
    a_noval: assert property (@(posedge clk) chk_noval |-> !valid_o)
        else report_err("valid_o high after an exception");
    a_hold: assert property (@(posedge clk) disable iff (!resetn)
        !ready_i |=> $stable(out_o) && $stable(valid_o))
        else report_err("output changed under back-pressure");

    task automatic exec_op(input exec_op_e op, input logic [31:0] rs, input logic [31:0] rt,
                           input logic [15:0] imm, input logic exc, input exc_code_e code,
                           input logic irq, input int ok_delay, input int stall);
        int waited;
        logic is_mem;
        @(negedge clk);
        chk_out = 1'b0;
        chk_noval = 1'b0;
        issue_i.op = op;
        issue_i.pc = $urandom & 32'hffff_fffc;
        issue_i.rs_val = rs;
        issue_i.rt_val = rt;
        issue_i.imm = imm;
        issue_i.sa = $urandom;
        issue_i.rt = $urandom;
        issue_i.rd = $urandom;
        issue_i.pc_b = $urandom;
        issue_i.pc_j = $urandom;
        valid_i = 1'b1;
        int_i = irq;
        ready_i = stall == 0;
        is_mem = op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_SB, OP_SH, OP_SW};
        exp_result = op_result(issue_i);
        exp_waddr = dest_reg(issue_i);
        exp_wb = writes(op);
        exp_branch = branch_taken(issue_i);
        exp_target = (op inside {OP_JR, OP_JALR}) ? rs
                   : (op inside {OP_J, OP_JAL}) ? issue_i.pc_j : issue_i.pc_b;
        exp_eaddr = eff_addr(issue_i);
        exp_mem = mem_request(issue_i);
        exp_code = code;
        chk_exc = exc;
        chk_noexc = !exc;
        chk_br = !exc;
        chk_mem = is_mem && !exc;
        waited = 0;
        forever begin
            @(posedge clk);
            if (done_o && ready_i) break;
            waited++;
            @(negedge clk);
            data_addr_ok_i = is_mem && waited >= ok_delay;
            ready_i = waited >= stall;
            // a finished move must ignore a changed operand
            if (op inside {OP_MTHI, OP_MTLO}) begin
                issue_i.rs_val = ~rs;
                exp_eaddr = eff_addr(issue_i);
            end
        end
        if (op inside {OP_CLZ, OP_CLO} && waited > 34) report_err("count took too long");
        if (!exc && op == OP_MTHI) hi_model = rs;
        if (!exc && op == OP_MTLO) lo_model = rs;
        @(negedge clk);
        {valid_i, int_i, data_addr_ok_i} = 3'b000;
        {chk_br, chk_mem, chk_exc, chk_noexc} = 4'b0000;
        chk_out = !exc;
        chk_noval = exc;
        tests++;
    endtask

    task automatic show_progress(input string name);
        $display("%s finished, %0d errors so far", name, errors);
    endtask

    initial begin
        logic [31:0] a, b, v;
        exec_op_e op;
        {valid_i, int_i, data_addr_ok_i} = 3'b000;
        ready_i = 1'b1;
        issue_i = '0;
        {chk_out, chk_br, chk_mem, chk_exc, chk_noexc, chk_noval} = '0;
        {errors, tests, hi_model, lo_model} = '0;
        void'($urandom(32'h2de06f36));
        @(posedge resetn);

        for (int r = 0; r < 4; r++) begin
            foreach (alu_ops[i]) begin
                // keep the trapping forms clear of overflow
                a = (alu_ops[i] inside {OP_ADD, OP_SUB, OP_ADDI}) ? $urandom >> 2 : $urandom;
                b = (alu_ops[i] inside {OP_ADD, OP_SUB}) ? $urandom >> 2 : $urandom;
                exec_op(alu_ops[i], a, b, $urandom, 0, EXC_INT, 0, 0, 0);
            end
        end
        show_progress("alu");

        for (int r = 0; r < 4; r++) begin
            foreach (br_ops[i]) begin
                a = $urandom;
                b = r[0] ? a : $urandom;
                exec_op(br_ops[i], a, b, $urandom, 0, EXC_INT, 0, 0, 0);
            end
        end
        show_progress("branch");

        for (int r = 0; r < 8; r++) begin
            exec_op(OP_SB, $urandom, $urandom, $urandom, 0, EXC_INT, 0, $urandom % 4, 0);
            exec_op(OP_SH, $urandom & ~1, $urandom, $urandom & 16'hfffe, 0, EXC_INT, 0,
                    $urandom % 4, 0);
            exec_op(OP_SW, $urandom & ~3, $urandom, $urandom & 16'hfffc, 0, EXC_INT, 0,
                    $urandom % 4, 0);
        end
        exec_op(OP_LH, $urandom | 1, 0, 0, 1, EXC_ADEL, 0, 0, 0);
        exec_op(OP_LW, ($urandom & ~3) | 2, 0, 0, 1, EXC_ADEL, 0, 0, 0);
        exec_op(OP_SH, $urandom | 1, 0, 0, 1, EXC_ADES, 0, 0, 0);
        exec_op(OP_SW, $urandom | 1, 0, 0, 1, EXC_ADES, 0, 0, 0);
        show_progress("memory");

        exec_op(OP_ADD, 32'h7fff_ffff, 32'd1, 0, 1, EXC_OV, 0, 0, 0);
        exec_op(OP_ADDU, 32'h7fff_ffff, 32'd1, 0, 0, EXC_INT, 0, 0, 0);
        exec_op(OP_RESERVED, $urandom, $urandom, 0, 1, EXC_RI, 0, 0, 0);
        exec_op(OP_RESERVED, $urandom, $urandom, 0, 1, EXC_INT, 1, 0, 0);
        exec_op(OP_ADD, 32'h7fff_ffff, 32'd1, 0, 1, EXC_INT, 1, 0, 0);
        exec_op(OP_SW, $urandom | 1, 0, 0, 1, EXC_INT, 1, 0, 0);
        show_progress("exception");

        for (int r = 0; r < 5; r++) begin
            exec_op(OP_MTHI, $urandom, 0, 0, 0, EXC_INT, 0, 0, 1 + $urandom % 6);
            exec_op(OP_MTLO, $urandom, 0, 0, 0, EXC_INT, 0, 0, $urandom % 4);
            exec_op(OP_MFHI, 0, 0, 0, 0, EXC_INT, 0, 0, $urandom % 4);
            exec_op(OP_MFLO, 0, 0, 0, 0, EXC_INT, 0, 0, 1 + $urandom % 6);
        end
        show_progress("hilo");

        for (int r = 0; r < 12; r++) begin
            op = r[0] ? OP_CLO : OP_CLZ;
            v = (r < 2) ? 32'd0 : (r < 4) ? 32'hffff_ffff : ($urandom >> ($urandom % 33));
            if (op == OP_CLO && r >= 4) v = ~v;
            exec_op(op, v, 0, 0, 0, EXC_INT, 0, 0, 0);
        end
        show_progress("count");

        @(negedge clk);
        chk_out = 1'b0;
        chk_noval = 1'b0;
        $display("%0d instructions run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
    output logic clk_o,
    output logic resetn_o
);
    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    // reset held for four rising edges
    initial begin
        resetn_o = 1'b0;
        repeat (4) @(posedge clk_o);
        @(negedge clk_o);
        resetn_o = 1'b1;
    end

endmodule

// File: logic/execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      valid_i,
    input  exec_pkg::issue_t          issue_i,
    input  logic                      ready_i,
    input  logic                      int_i,
    input  logic                      data_addr_ok_i,
    output logic                      done_o,
    output logic                      valid_o,
    output exec_pkg::stage_out_t      out_o,
    output exec_pkg::mem_req_t        mem_o,
    output logic                      branch_o,
    output logic [exec_pkg::XLEN-1:0] target_pc_o,
    output logic                      commit_o,
    output exec_pkg::commit_t         commit_info_o
);
    import exec_pkg::*;

    ctrl_t             ctrl;
    logic [REG_AW-1:0] waddr;
    logic              reserved;
    logic [XLEN-1:0]   imm_ext, alu_a, alu_b, alu_res;
    logic [XLEN-1:0]   eaddr, result;
    logic              alu_ovf, taken, adel, ades;
    mem_req_t          mem_fields;
    logic              cnt_done;
    logic [5:0]        cnt_value;
    logic [XLEN-1:0]   hi_q, lo_q;
    logic              done_q, exc_q;
    logic              valid, mem_op, ovf, exc_now, exc_any, work_done;
    exc_code_e         exc_code;

    // instruction already finished while stalled
    assign valid  = valid_i && !done_q;
    assign mem_op = ctrl.is_load || ctrl.is_store;

    op_decode i_decode (
        .op_i       (issue_i.op),
        .rt_i       (issue_i.rt),
        .rd_i       (issue_i.rd),
        .ctrl_o     (ctrl),
        .waddr_o    (waddr),
        .reserved_o (reserved)
    );

    assign imm_ext = ctrl.imm_signed ? {{(XLEN-16){issue_i.imm[15]}}, issue_i.imm}
                                     : {{(XLEN-16){1'b0}}, issue_i.imm};
    assign alu_a = ctrl.a_is_sa ? {{(XLEN-5){1'b0}}, issue_i.sa} : issue_i.rs_val;
    assign alu_b = ctrl.b_is_imm ? imm_ext : issue_i.rt_val;

    int_alu i_alu (
        .alu_op_i   (ctrl.alu_op),
        .a_i        (alu_a),
        .b_i        (alu_b),
        .result_o   (alu_res),
        .overflow_o (alu_ovf)
    );

    branch_unit i_branch (
        .ctrl_i   (ctrl),
        .op_i     (issue_i.op),
        .rs_val_i (issue_i.rs_val),
        .rt_val_i (issue_i.rt_val),
        .pc_b_i   (issue_i.pc_b),
        .pc_j_i   (issue_i.pc_j),
        .taken_o  (taken),
        .target_o (target_pc_o)
    );

    mem_addr_gen i_mem_addr (
        .ctrl_i       (ctrl),
        .op_i         (issue_i.op),
        .rs_val_i     (issue_i.rs_val),
        .rt_val_i     (issue_i.rt_val),
        .imm_i        (issue_i.imm),
        .eaddr_o      (eaddr),
        .adel_o       (adel),
        .ades_o       (ades),
        .req_fields_o (mem_fields)
    );

    count_lead_unit i_count (
        .clk     (clk),
        .resetn  (resetn),
        .start_i (valid && ctrl.is_count && !exc_now),
        .ones_i  (ctrl.count_ones),
        .data_i  (issue_i.rs_val),
        .clear_i (ready_i && done_o),
        .done_o  (cnt_done),
        .count_o (cnt_value)
    );

    // exception ranking INT, RI, OV, then address errors
    assign ovf     = ctrl.ovf_exc && alu_ovf;
    assign exc_now = int_i || reserved || ovf || adel || ades;

    always_comb begin
        if (int_i) exc_code = EXC_INT;
        else if (reserved) exc_code = EXC_RI;
        else if (ovf) exc_code = EXC_OV;
        else if (adel) exc_code = EXC_ADEL;
        else exc_code = EXC_ADES;
    end

    assign commit_o      = valid && exc_now;
    assign commit_info_o = '{code: exc_code, epc: issue_i.pc, bvaddr: eaddr};
    assign branch_o      = valid && taken && !exc_now;

    always_comb begin
        mem_o = mem_fields;
        mem_o.req = valid && mem_op && !exc_now;
    end

    assign work_done = exc_now || (mem_op ? data_addr_ok_i : (ctrl.is_count ? cnt_done : 1'b1));
    assign done_o    = valid_i && (done_q || work_done);
    assign exc_any   = done_q ? exc_q : exc_now;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            done_q <= 1'b0;
        end else if (ready_i) begin
            done_q <= 1'b0;
        end else if (valid && done_o) begin
            done_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (valid && done_o) begin
            exc_q <= exc_now;
        end
    end

    // mthi/mtlo take effect once, only without exception
    always_ff @(posedge clk) begin
        if (valid && !exc_now && issue_i.op == OP_MTHI) begin
            hi_q <= issue_i.rs_val;
        end
        if (valid && !exc_now && issue_i.op == OP_MTLO) begin
            lo_q <= issue_i.rs_val;
        end
    end

    always_comb begin
        result = alu_res;
        if (ctrl.is_link) result = issue_i.pc + 32'd8;
        else if (ctrl.is_count) result = {{(XLEN-6){1'b0}}, cnt_value};
        else if (issue_i.op == OP_LUI) result = {issue_i.imm, 16'h0000};
        else if (issue_i.op == OP_MFHI) result = hi_q;
        else if (issue_i.op == OP_MFLO) result = lo_q;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_o <= 1'b0;
        end else if (ready_i) begin
            valid_o <= valid_i && done_o && !exc_any;
        end
    end

    always_ff @(posedge clk) begin
        if (ready_i) begin
            out_o.pc     <= issue_i.pc;
            out_o.op     <= issue_i.op;
            out_o.waddr  <= ctrl.wb_en ? waddr : '0;
            out_o.result <= result;
            out_o.eaddr  <= eaddr;
            out_o.rt_val <= issue_i.rt_val;
        end
    end

endmodule

// File: logic/count_lead_unit.sv
`timescale 1ns/100ps

module count_lead_unit (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      start_i,
    input  logic                      ones_i,
    input  logic [exec_pkg::XLEN-1:0] data_i,
    input  logic                      clear_i,
    output logic                      done_o,
    output logic [5:0]                count_o
);
    import exec_pkg::*;

    logic            busy_q;
    logic [XLEN-1:0] shift_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy_q <= 1'b0;
        end else if (clear_i) begin
            busy_q <= 1'b0;
        end else if (start_i) begin
            busy_q <= 1'b1;
        end
    end

    // clz counts leading ones of the inverted operand
    always_ff @(posedge clk) begin
        if (start_i && !busy_q) begin
            shift_q <= ones_i ? data_i : ~data_i;
            count_o <= '0;
        end else if (busy_q && shift_q[XLEN-1] && !count_o[5]) begin
            shift_q <= shift_q << 1;
            count_o <= count_o + 6'd1;
        end
    end

    // held until the stage advances
    assign done_o = busy_q && (!shift_q[XLEN-1] || count_o[5]);

endmodule

// File: logic/mem_addr_gen.sv
`timescale 1ns/100ps

module mem_addr_gen (
    input  exec_pkg::ctrl_t           ctrl_i,
    input  exec_pkg::exec_op_e        op_i,
    input  logic [exec_pkg::XLEN-1:0] rs_val_i,
    input  logic [exec_pkg::XLEN-1:0] rt_val_i,
    input  logic [15:0]               imm_i,
    output logic [exec_pkg::XLEN-1:0] eaddr_o,
    output logic                      adel_o,
    output logic                      ades_o,
    output exec_pkg::mem_req_t        req_fields_o
);
    import exec_pkg::*;

    logic [XLEN-1:0] aligned;
    logic [1:0]      offset;
    mem_size_e       size;
    logic            misaligned;
    logic            kseg01;

    assign eaddr_o = rs_val_i + {{(XLEN-16){imm_i[15]}}, imm_i};
    assign offset  = eaddr_o[1:0];
    assign aligned = {eaddr_o[XLEN-1:2], 2'b00};

    always_comb begin
        case (op_i)
            OP_LB, OP_LBU, OP_SB: size = SIZE_BYTE;
            OP_LH, OP_LHU, OP_SH: size = SIZE_HALF;
            default:              size = SIZE_WORD;
        endcase
    end

    assign misaligned = (size == SIZE_HALF && offset[0])
                     || (size == SIZE_WORD && offset != 2'b00);
    assign adel_o = ctrl_i.is_load && misaligned;
    assign ades_o = ctrl_i.is_store && misaligned;

    // kseg0/kseg1 fold onto the low 512M
    assign kseg01 = aligned[XLEN-1:XLEN-2] == 2'b10;

    always_comb begin
        req_fields_o        = '0;
        req_fields_o.wr     = ctrl_i.is_store;
        req_fields_o.cached = aligned[XLEN-1:XLEN-3] == 3'b100;
        req_fields_o.addr   = kseg01 ? {3'b000, aligned[XLEN-4:0]} : aligned;
        req_fields_o.size   = size;
        case (size)
            SIZE_BYTE: begin
                req_fields_o.wstrb = 4'b0001 << offset;
                req_fields_o.wdata = {4{rt_val_i[7:0]}};
            end
            SIZE_HALF: begin
                req_fields_o.wstrb = 4'b0011 << offset;
                req_fields_o.wdata = {2{rt_val_i[15:0]}};
            end
            default: begin
                req_fields_o.wstrb = 4'b1111;
                req_fields_o.wdata = rt_val_i;
            end
        endcase
        // loads never write
        if (!ctrl_i.is_store) begin
            req_fields_o.wstrb = 4'b0000;
        end
    end

endmodule

// File: logic/branch_unit.sv
`timescale 1ns/100ps

module branch_unit (
    input  exec_pkg::ctrl_t           ctrl_i,
    input  exec_pkg::exec_op_e        op_i,
    input  logic [exec_pkg::XLEN-1:0] rs_val_i,
    input  logic [exec_pkg::XLEN-1:0] rt_val_i,
    input  logic [exec_pkg::XLEN-1:0] pc_b_i,
    input  logic [exec_pkg::XLEN-1:0] pc_j_i,
    output logic                      taken_o,
    output logic [exec_pkg::XLEN-1:0] target_o
);
    import exec_pkg::*;

    logic eq, ltz, lez, cond;

    assign eq  = rs_val_i == rt_val_i;
    assign ltz = rs_val_i[XLEN-1];
    assign lez = ltz || (rs_val_i == '0);

    always_comb begin
        case (op_i)
            OP_BEQ:                cond = eq;
            OP_BNE:                cond = !eq;
            OP_BLEZ:               cond = lez;
            OP_BGTZ:               cond = !lez;
            OP_BLTZ, OP_BLTZAL:    cond = ltz;
            OP_BGEZ, OP_BGEZAL:    cond = !ltz;
            default:               cond = 1'b0;
        endcase
    end

    assign taken_o  = ctrl_i.is_jump || (ctrl_i.is_branch && cond);
    assign target_o = ctrl_i.is_jr ? rs_val_i : (ctrl_i.is_jump ? pc_j_i : pc_b_i);

endmodule

// File: logic/int_alu.sv
`timescale 1ns/100ps

module int_alu (
    input  exec_pkg::alu_op_e         alu_op_i,
    input  logic [exec_pkg::XLEN-1:0] a_i,
    input  logic [exec_pkg::XLEN-1:0] b_i,
    output logic [exec_pkg::XLEN-1:0] result_o,
    output logic                      overflow_o
);
    import exec_pkg::*;

    logic            sub;
    logic [XLEN-1:0] b_eff;
    logic [XLEN:0]   sum;
    logic            lt_signed;
    logic            lt_unsigned;
    logic [4:0]      shamt;

    // one adder serves add, sub and both compares
    assign sub   = alu_op_i inside {ALU_SUB, ALU_SLT, ALU_SLTU};
    assign b_eff = sub ? ~b_i : b_i;
    assign sum   = {1'b0, a_i} + {1'b0, b_eff} + {{XLEN{1'b0}}, sub};

    assign lt_unsigned = !sum[XLEN];
    assign lt_signed   = (a_i[XLEN-1] != b_i[XLEN-1]) ? a_i[XLEN-1] : sum[XLEN-1];

    // shift amount from a, value from b
    assign shamt = a_i[4:0];

    // same operand signs but the sum sign flips
    assign overflow_o = (alu_op_i inside {ALU_ADD, ALU_SUB})
                     && (a_i[XLEN-1] == b_eff[XLEN-1])
                     && (sum[XLEN-1] != a_i[XLEN-1]);

    always_comb begin
        case (alu_op_i)
            ALU_AND:  result_o = a_i & b_i;
            ALU_OR:   result_o = a_i | b_i;
            ALU_XOR:  result_o = a_i ^ b_i;
            ALU_NOR:  result_o = ~(a_i | b_i);
            ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_SLL:  result_o = b_i << shamt;
            ALU_SRL:  result_o = b_i >> shamt;
            ALU_SRA:  result_o = $signed(b_i) >>> shamt;
            default:  result_o = sum[XLEN-1:0];
        endcase
    end

endmodule

// File: logic/op_decode.sv
`timescale 1ns/100ps

module op_decode (
    input  exec_pkg::exec_op_e          op_i,
    input  logic [exec_pkg::REG_AW-1:0] rt_i,
    input  logic [exec_pkg::REG_AW-1:0] rd_i,
    output exec_pkg::ctrl_t             ctrl_o,
    output logic [exec_pkg::REG_AW-1:0] waddr_o,
    output logic                        reserved_o
);
    import exec_pkg::*;

    always_comb begin
        ctrl_o = '0;
        waddr_o = '0;

        case (op_i)
            OP_SUB, OP_SUBU:           ctrl_o.alu_op = ALU_SUB;
            OP_AND, OP_ANDI:           ctrl_o.alu_op = ALU_AND;
            OP_OR, OP_ORI:             ctrl_o.alu_op = ALU_OR;
            OP_XOR, OP_XORI:           ctrl_o.alu_op = ALU_XOR;
            OP_NOR:                    ctrl_o.alu_op = ALU_NOR;
            OP_SLT, OP_SLTI:           ctrl_o.alu_op = ALU_SLT;
            OP_SLTU, OP_SLTIU:         ctrl_o.alu_op = ALU_SLTU;
            OP_SLL, OP_SLLV:           ctrl_o.alu_op = ALU_SLL;
            OP_SRL, OP_SRLV:           ctrl_o.alu_op = ALU_SRL;
            OP_SRA, OP_SRAV:           ctrl_o.alu_op = ALU_SRA;
            default:                   ctrl_o.alu_op = ALU_ADD;
        endcase

        // operand selection
        ctrl_o.a_is_sa    = op_i inside {OP_SLL, OP_SRL, OP_SRA};
        ctrl_o.b_is_imm   = op_i inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
                                         OP_ANDI, OP_ORI, OP_XORI};
        ctrl_o.imm_signed = !(op_i inside {OP_ANDI, OP_ORI, OP_XORI});
        ctrl_o.ovf_exc    = op_i inside {OP_ADD, OP_SUB, OP_ADDI};

        // instruction class
        ctrl_o.is_load    = op_i inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
        ctrl_o.is_store   = op_i inside {OP_SB, OP_SH, OP_SW};
        ctrl_o.is_branch  = op_i inside {OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ,
                                         OP_BLTZ, OP_BGEZ, OP_BLTZAL, OP_BGEZAL};
        ctrl_o.is_jump    = op_i inside {OP_J, OP_JAL, OP_JR, OP_JALR};
        ctrl_o.is_jr      = op_i inside {OP_JR, OP_JALR};
        ctrl_o.is_link    = op_i inside {OP_BLTZAL, OP_BGEZAL, OP_JAL, OP_JALR};
        ctrl_o.is_count   = op_i inside {OP_CLZ, OP_CLO};
        ctrl_o.count_ones = op_i == OP_CLO;

        // destination register
        case (op_i)
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_AND, OP_OR, OP_XOR, OP_NOR,
            OP_SLT, OP_SLTU, OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV,
            OP_MFHI, OP_MFLO, OP_CLZ, OP_CLO, OP_JALR: begin
                waddr_o = rd_i;
                ctrl_o.wb_en = 1'b1;
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: begin
                waddr_o = rt_i;
                ctrl_o.wb_en = 1'b1;
            end
            OP_BLTZAL, OP_BGEZAL, OP_JAL: begin
                waddr_o = LINK_REG;
                ctrl_o.wb_en = 1'b1;
            end
            default: begin
                waddr_o = '0;
                ctrl_o.wb_en = 1'b0;
            end
        endcase
    end

    // unused encodings above the table count as reserved too
    assign reserved_o = op_i >= OP_RESERVED;

endmodule

// File: logic/exec_pkg.sv
package exec_pkg;

    localparam int XLEN = 32;
    localparam int REG_AW = 5;
    localparam logic [REG_AW-1:0] LINK_REG = 5'd31;

    // issued instruction, one value per supported opcode
    typedef enum logic [5:0] {
        OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
        OP_AND, OP_OR, OP_XOR, OP_NOR,
        OP_SLT, OP_SLTU,
        OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV,
        OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
        OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
        OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ,
        OP_BLTZ, OP_BGEZ, OP_BLTZAL, OP_BGEZAL,
        OP_J, OP_JAL, OP_JR, OP_JALR,
        OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO,
        OP_CLZ, OP_CLO,
        OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW,
        OP_SB, OP_SH, OP_SW,
        OP_NOP,
        OP_RESERVED
    } exec_op_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_e;

    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5,
        EXC_RI   = 5'd10,
        EXC_OV   = 5'd12
    } exc_code_e;

    typedef enum logic [2:0] {
        SIZE_BYTE = 3'd0,
        SIZE_HALF = 3'd1,
        SIZE_WORD = 3'd2
    } mem_size_e;

    typedef struct packed {
        exec_op_e          op;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   rs_val;
        logic [XLEN-1:0]   rt_val;
        logic [15:0]       imm;
        logic [4:0]        sa;
        logic [REG_AW-1:0] rt;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   pc_b;
        logic [XLEN-1:0]   pc_j;
    } issue_t;

    typedef struct packed {
        alu_op_e alu_op;
        logic    a_is_sa;
        logic    b_is_imm;
        logic    imm_signed;
        logic    ovf_exc;
        logic    is_load;
        logic    is_store;
        logic    is_branch;
        logic    is_jump;
        logic    is_jr;
        logic    is_link;
        logic    is_count;
        logic    count_ones;
        logic    wb_en;
    } ctrl_t;

    typedef struct packed {
        logic            req;
        logic            wr;
        logic            cached;
        logic [3:0]      wstrb;
        logic [XLEN-1:0] addr;
        mem_size_e       size;
        logic [XLEN-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        exec_op_e          op;
        logic [REG_AW-1:0] waddr;
        logic [XLEN-1:0]   result;
        logic [XLEN-1:0]   eaddr;
        logic [XLEN-1:0]   rt_val;
    } stage_out_t;

    typedef struct packed {
        exc_code_e       code;
        logic [XLEN-1:0] epc;
        logic [XLEN-1:0] bvaddr;
    } commit_t;

endpackage
